// ==== include/phy_test_config.svh ====
// PHY self-test configuration: widths, packet shape, header marker and register map
`ifndef PHY_TEST_CONFIG_SVH
`define PHY_TEST_CONFIG_SVH

// Bus and field widths
`define PHY_TEST_DATA_WIDTH      32
`define PHY_TEST_REG_ADDR_WIDTH  3
`define PHY_TEST_SEQ_NO_WIDTH    21

// Packet shape, one header word plus seven payload words
`define PHY_TEST_PKT_WORDS       8
`define PHY_TEST_MARKER          8'hA5
`define PHY_TEST_SRC_PORT        3'd5

// RX register word offsets
`define PHY_TEST_RX_STATUS       0
`define PHY_TEST_RX_GOOD_PKT_CNT 1
`define PHY_TEST_RX_ERR_PKT_CNT  2
`define PHY_TEST_RX_SEQ_NO       3
`define PHY_TEST_RX_CTRL         4

// Clear bits of a CTRL write
`define PHY_TEST_RX_CTRL_RESET_GOOD_POS 0
`define PHY_TEST_RX_CTRL_RESET_ERR_POS  1

`endif

// ==== source/phy_test_pkg.sv ====
// Packet stream types shared by the generator, the checker and the control logic
`include "phy_test_config.svh"

package phy_test_pkg;

   // ==========================================================
   // Packet words

   // Header layout of word 0
   typedef struct packed {
      logic [7:0]                        marker;
      logic [2:0]                        src_port;
      logic [`PHY_TEST_SEQ_NO_WIDTH-1:0] seq_no;
   } pkt_hdr_t;

   // Word 0 is read through hdr, payload words through raw
   typedef union packed {
      logic [`PHY_TEST_DATA_WIDTH-1:0] raw;
      pkt_hdr_t                        hdr;
   } pkt_word_u;

   // One word per cycle, no back-pressure
   typedef struct packed {
      logic      valid;
      logic      sop;
      pkt_word_u data;
   } stream_t;

   // ==========================================================
   // Checker results

   typedef struct packed {
      logic                              good_pkt;
      logic                              err_pkt;
      logic [`PHY_TEST_SEQ_NO_WIDTH-1:0] seq_no;
      logic                              seq_no_valid;
      logic                              locked;
      logic [2:0]                        src_port;
   } rx_status_t;

endpackage

// ==== source/phy_test_reg_pkg.sv ====
// Host register access types and the RX status register layout
`include "phy_test_config.svh"

package phy_test_reg_pkg;

   // Host request, held until ack is seen
   typedef struct packed {
      logic                                req;
      logic                                rd_wr_l;   // 1 = read
      logic [`PHY_TEST_REG_ADDR_WIDTH-1:0] addr;
      logic [`PHY_TEST_DATA_WIDTH-1:0]     wr_data;
   } reg_req_t;

   // Single-cycle ack with read data alongside
   typedef struct packed {
      logic                            ack;
      logic [`PHY_TEST_DATA_WIDTH-1:0] rd_data;
   } reg_rsp_t;

   // ==========================================================
   // Status word, one flag per nibble

   typedef struct packed {
      logic [12:0] zero_port;
      logic [2:0]  src_port;
      logic [2:0]  zero_valid;
      logic        seq_no_valid;
      logic [2:0]  zero_locked;
      logic        locked;
      logic [2:0]  zero_pass;
      logic        pass;
      logic [2:0]  zero_done;
      logic        done;
   } rx_status_word_t;

endpackage

// ==== source/phy_test_ctrl.sv ====
// Run control for the PHY self-test: starts the run, counts packet events, decides pass
module phy_test_ctrl (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic [15:0]             num_pkts,
   input  phy_test_pkg::rx_status_t rx_status,
   output logic                    active,
   output logic                    tx_en,
   output logic                    done,
   output logic                    pass
);

   typedef enum logic {
      IDLE,
      RUN
   } state_t;

   state_t      state;
   logic [15:0] target;
   logic [15:0] rcv_cnt;
   logic [15:0] err_cnt;
   logic [15:0] rcv_next;
   logic [15:0] err_next;

   // Counts including this cycle's event
   always_comb begin
      rcv_next = rcv_cnt + 16'(rx_status.good_pkt) + 16'(rx_status.err_pkt);
      err_next = err_cnt + 16'(rx_status.err_pkt);
   end

   // ==========================================================
   // Idle/run FSM

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         done    <= 1'b0;
         pass    <= 1'b0;
         target  <= '0;
         rcv_cnt <= '0;
         err_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state   <= RUN;
                  done    <= 1'b0;
                  pass    <= 1'b0;
                  target  <= num_pkts;
                  rcv_cnt <= '0;
                  err_cnt <= '0;
               end
            end
            RUN: begin
               rcv_cnt <= rcv_next;
               err_cnt <= err_next;
               // Last expected event ends the run
               if (rcv_next == target) begin
                  state <= IDLE;
                  done  <= 1'b1;
                  pass  <= (err_next == '0) && rx_status.locked;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign active = (state == RUN);
   assign tx_en  = (state == RUN);

endmodule

// ==== source/phy_test_pat_gen.sv ====
// Test pattern generator: numbered packets, one word per cycle, while enabled
`include "phy_test_config.svh"

module phy_test_pat_gen (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 tx_en,
   input  logic [15:0]          num_pkts,
   output phy_test_pkg::stream_t tx
);

   localparam int IDX_W = $clog2(`PHY_TEST_PKT_WORDS);
   localparam int SEQ_W = `PHY_TEST_SEQ_NO_WIDTH;
   localparam logic [IDX_W-1:0] LAST_POS = IDX_W'(`PHY_TEST_PKT_WORDS - 1);

   logic [IDX_W-1:0]       word_idx;
   logic [SEQ_W-1:0]       seq_cnt;
   logic                   more;
   phy_test_pkg::pkt_word_u next_word;

   assign more = (seq_cnt < SEQ_W'(num_pkts));

   // Header through the hdr view, payload through raw
   always_comb begin
      next_word.raw = {8'(word_idx), 3'b000, seq_cnt};
      if (word_idx == '0) begin
         next_word.hdr.marker   = `PHY_TEST_MARKER;
         next_word.hdr.src_port = `PHY_TEST_SRC_PORT;
         next_word.hdr.seq_no   = seq_cnt;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || !tx_en) begin
         tx.valid <= 1'b0;
         word_idx <= '0;
         seq_cnt  <= '0;
      end else if (more) begin
         tx.valid <= 1'b1;
         word_idx <= word_idx + 1'b1;
         if (word_idx == LAST_POS) begin
            seq_cnt <= seq_cnt + 1'b1;
         end
      end else begin
         tx.valid <= 1'b0;
      end
   end

   // Word payload, qualified by valid
   always_ff @(posedge clk) begin
      tx.sop  <= (word_idx == '0);
      tx.data <= next_word;
   end

endmodule

// ==== source/phy_test_rx_check.sv ====
// Receive checker: tests header, sequence and payload of each packet, one event per packet
`include "phy_test_config.svh"

module phy_test_rx_check (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     active,
   input  phy_test_pkg::stream_t     rx,
   output phy_test_pkg::rx_status_t  rx_status
);

   localparam int IDX_W = $clog2(`PHY_TEST_PKT_WORDS);
   localparam int SEQ_W = `PHY_TEST_SEQ_NO_WIDTH;
   localparam logic [IDX_W-1:0] LAST_POS = IDX_W'(`PHY_TEST_PKT_WORDS - 1);

   logic                   in_pkt;
   logic [IDX_W-1:0]       word_pos;
   logic [SEQ_W-1:0]       exp_seq;
   logic [SEQ_W-1:0]       hdr_seq;
   logic [2:0]             hdr_src;
   logic                   pkt_err;
   logic                   seq_ok;
   logic                   hdr_bad;
   logic                   hdr_seq_ok;
   logic                   pay_bad;
   logic                   pay_seq_ok;
   phy_test_pkg::pkt_word_u exp_word;

   // ==========================================================
   // Per-word checks

   always_comb begin
      exp_word.raw = {8'(word_pos), 3'b000, exp_seq};
      hdr_seq_ok   = (rx.data.hdr.seq_no == exp_seq);
      hdr_bad      = (rx.data.hdr.marker != `PHY_TEST_MARKER) || !hdr_seq_ok;
      pay_bad      = (rx.data.raw != exp_word.raw);
      // Any intact copy of the expected number confirms the sequence
      pay_seq_ok   = (rx.data.raw[SEQ_W-1:0] == exp_seq);
   end

   // ==========================================================
   // Packet tracking and result pulses

   always_ff @(posedge clk) begin
      if (reset || !active) begin
         in_pkt    <= 1'b0;
         word_pos  <= '0;
         exp_seq   <= '0;
         pkt_err   <= 1'b0;
         seq_ok    <= 1'b0;
         rx_status <= '0;
      end else begin
         rx_status.good_pkt <= 1'b0;
         rx_status.err_pkt  <= 1'b0;
         if (rx.valid && rx.sop) begin
            // Sop inside a packet truncates the previous one
            if (in_pkt) begin
               rx_status.err_pkt <= 1'b1;
               rx_status.locked  <= 1'b0;
            end
            in_pkt                 <= 1'b1;
            word_pos               <= IDX_W'(1);
            pkt_err                <= hdr_bad;
            seq_ok                 <= hdr_seq_ok;
            hdr_seq                <= rx.data.hdr.seq_no;
            hdr_src                <= rx.data.hdr.src_port;
            rx_status.seq_no       <= rx.data.hdr.seq_no;
            rx_status.seq_no_valid <= 1'b1;
         end else if (rx.valid && in_pkt) begin
            word_pos <= word_pos + 1'b1;
            pkt_err  <= pkt_err | pay_bad;
            seq_ok   <= seq_ok | pay_seq_ok;
            if (word_pos == LAST_POS) begin
               in_pkt <= 1'b0;
               if (pkt_err || pay_bad) begin
                  rx_status.err_pkt <= 1'b1;
                  rx_status.locked  <= 1'b0;
               end else begin
                  rx_status.good_pkt <= 1'b1;
                  rx_status.locked   <= 1'b1;
                  rx_status.src_port <= hdr_src;
               end
               // Resync only when the whole packet disagrees with the expected number
               exp_seq <= (seq_ok || pay_seq_ok) ? exp_seq + 1'b1 : hdr_seq + 1'b1;
            end
         end
      end
   end

endmodule

// ==== source/phy_test_rx_reg.sv ====
// RX register block: status readback, clearable good/error counters, last sequence number
`include "phy_test_config.svh"

module phy_test_rx_reg (
   input  logic                        clk,
   input  logic                        reset,
   input  phy_test_reg_pkg::reg_req_t   host_req,
   output phy_test_reg_pkg::reg_rsp_t   host_rsp,
   input  logic                        active,
   input  phy_test_pkg::rx_status_t     rx_status,
   input  logic                        done,
   input  logic                        pass
);

   localparam int DW    = `PHY_TEST_DATA_WIDTH;
   localparam int SEQ_W = `PHY_TEST_SEQ_NO_WIDTH;

   logic             req_seen;
   logic             new_req;
   logic             wr_ctrl;
   logic             ack;
   logic [DW-1:0]    rd_data;
   logic [DW-1:0]    rd_mux;
   logic             clr_good;
   logic             clr_err;
   logic             active_d1;
   logic [DW-1:0]    good_cnt;
   logic [DW-1:0]    err_cnt;
   logic             lat_locked;
   logic [2:0]       lat_src_port;
   logic [SEQ_W-1:0] lat_seq_no;
   logic             lat_seq_valid;
   phy_test_reg_pkg::rx_status_word_t status_word;

   assign new_req = host_req.req && !req_seen;
   assign wr_ctrl = new_req && !host_req.rd_wr_l &&
                    (host_req.addr == `PHY_TEST_RX_CTRL);

   // ==========================================================
   // Read decode

   always_comb begin
      status_word              = '0;
      status_word.src_port     = lat_src_port;
      status_word.seq_no_valid = lat_seq_valid;
      status_word.locked       = lat_locked;
      status_word.pass         = pass;
      status_word.done         = done;
      case (host_req.addr)
         `PHY_TEST_RX_STATUS:       rd_mux = status_word;
         `PHY_TEST_RX_GOOD_PKT_CNT: rd_mux = good_cnt;
         `PHY_TEST_RX_ERR_PKT_CNT:  rd_mux = err_cnt;
         `PHY_TEST_RX_SEQ_NO:       rd_mux = DW'(lat_seq_no);
         `PHY_TEST_RX_CTRL:         rd_mux = '0;
         default:                   rd_mux = 32'hDEAD_BEEF;
      endcase
   end

   // ==========================================================
   // Request/ack handshake, one ack per raised req

   always_ff @(posedge clk) begin
      if (reset) begin
         req_seen <= 1'b0;
         ack      <= 1'b0;
         clr_good <= 1'b0;
         clr_err  <= 1'b0;
      end else begin
         req_seen <= host_req.req;
         ack      <= new_req;
         clr_good <= wr_ctrl && host_req.wr_data[`PHY_TEST_RX_CTRL_RESET_GOOD_POS];
         clr_err  <= wr_ctrl && host_req.wr_data[`PHY_TEST_RX_CTRL_RESET_ERR_POS];
      end
   end

   always_ff @(posedge clk) begin
      if (new_req) begin
         rd_data <= rd_mux;
      end
   end

   assign host_rsp.ack     = ack;
   assign host_rsp.rd_data = rd_data;

   // ==========================================================
   // Counters and latched status, restarted by each new run

   always_ff @(posedge clk) begin
      if (reset || (active && !active_d1)) begin
         good_cnt      <= '0;
         err_cnt       <= '0;
         lat_locked    <= 1'b0;
         lat_src_port  <= '0;
         lat_seq_no    <= '0;
         lat_seq_valid <= 1'b0;
      end else begin
         // Clear wins over a same-cycle increment
         if (clr_good) begin
            good_cnt <= '0;
         end else if (active && rx_status.good_pkt) begin
            good_cnt <= good_cnt + 1'b1;
         end
         if (clr_err) begin
            err_cnt <= '0;
         end else if (active && rx_status.err_pkt) begin
            err_cnt <= err_cnt + 1'b1;
         end
         // Hold the last run's view once active drops
         if (active) begin
            lat_locked    <= rx_status.locked;
            lat_src_port  <= rx_status.src_port;
            lat_seq_no    <= rx_status.seq_no;
            lat_seq_valid <= rx_status.seq_no_valid;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         active_d1 <= 1'b0;
      end else begin
         active_d1 <= active;
      end
   end

endmodule

// ==== source/phy_test_top.sv ====
// PHY self-test top level: control, pattern generator, receive checker and registers
module phy_test_top (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       start,
   input  logic [15:0]                num_pkts,
   output phy_test_pkg::stream_t       tx,
   input  phy_test_pkg::stream_t       rx,
   input  phy_test_reg_pkg::reg_req_t  host_req,
   output phy_test_reg_pkg::reg_rsp_t  host_rsp,
   output logic                       done,
   output logic                       pass
);

   logic                    active;
   logic                    tx_en;
   phy_test_pkg::rx_status_t rx_status;

   phy_test_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .num_pkts  (num_pkts),
      .rx_status (rx_status),
      .active    (active),
      .tx_en     (tx_en),
      .done      (done),
      .pass      (pass)
   );

   phy_test_pat_gen u_pat_gen (
      .clk      (clk),
      .reset    (reset),
      .tx_en    (tx_en),
      .num_pkts (num_pkts),
      .tx       (tx)
   );

   // RX side sees the externally looped-back stream
   phy_test_rx_check u_rx_check (
      .clk       (clk),
      .reset     (reset),
      .active    (active),
      .rx        (rx),
      .rx_status (rx_status)
   );

   phy_test_rx_reg u_rx_reg (
      .clk       (clk),
      .reset     (reset),
      .host_req  (host_req),
      .host_rsp  (host_rsp),
      .active    (active),
      .rx_status (rx_status),
      .done      (done),
      .pass      (pass)
   );

endmodule

// ==== verif/phy_test_tb.sv ====
// Testbench for the PHY self-test top level: TX to RX loopback with bit flips, register checks
`include "phy_test_config.svh"

module phy_test_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_SCEN = 16;
   localparam int NCOL     = 18;
   localparam int C_CLR    = 13;
   localparam int C_GOOD   = 14;
   localparam int C_ERR    = 15;
   localparam int C_SEQ    = 16;
   localparam int C_PASS   = 17;

   logic                       clk = 1'b0;
   logic                       reset;
   logic                       start;
   logic [15:0]                num_pkts;
   phy_test_pkg::stream_t      tx;
   phy_test_pkg::stream_t      rx;
   phy_test_pkg::stream_t      rx_w;
   phy_test_reg_pkg::reg_req_t host_req;
   phy_test_reg_pkg::reg_rsp_t host_rsp;
   logic                       done;
   logic                       pass;

   logic [31:0] td [0:MAX_SCEN*NCOL-1];
   int          flip_pkt [4];
   int          flip_word [4];
   int          flip_bit [4];
   int          word_cnt = 0;
   int          errors = 0;
   int          limit = 0;
   int          n_scen = 0;
   int          scen_ok = 0;
   int          scen_bad = 0;
   int unsigned seed;

   phy_test_top dut0 (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .num_pkts (num_pkts),
      .tx       (tx),
      .rx       (rx),
      .host_req (host_req),
      .host_rsp (host_rsp),
      .done     (done),
      .pass     (pass)
   );

   always #10 clk = ~clk;

   // ==========================================================
   // Loopback, flips located by packet and word of the current run

   always @(negedge clk) begin
      rx_w = tx;
      if (tx.valid) begin
         check("tx.sop", 32'(word_cnt % 8 == 0), 32'(tx.sop));
         check("tx.data", tx_word_exp(word_cnt / 8, word_cnt % 8), tx.data.raw);
         for (int i = 0; i < 4; i++) begin
            if (flip_pkt[i] == word_cnt / 8 && flip_word[i] == word_cnt % 8) begin
               rx_w.data.raw[flip_bit[i]] = ~rx_w.data.raw[flip_bit[i]];
            end
         end
         word_cnt = word_cnt + 1;
      end else begin
         word_cnt = 0;
      end
      rx = rx_w;
   end

   // Watchdog sized from the scenario lengths
   initial begin
      wait (limit != 0);
      repeat (limit) @(posedge clk);
      $display("Run timed out after %0d cycles without finishing all scenarios", limit);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ==========================================================
   // Helpers

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERROR: t=%0t %s expected %h actual %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // Header or payload word of a numbered test packet
   function automatic logic [31:0] tx_word_exp(input int pkt, input int word);
      logic [31:0] w;
      if (word == 0) begin
         w = {`PHY_TEST_MARKER, `PHY_TEST_SRC_PORT, 21'(pkt)};
      end else begin
         w = {8'(word), 3'b000, 21'(pkt)};
      end
      return w;
   endfunction

   task automatic idle_gap();
      repeat ($urandom % 8) @(negedge clk);
   endtask

   task automatic reg_access(input logic rd, input logic [2:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      host_req.req     = 1'b1;
      host_req.rd_wr_l = rd;
      host_req.addr    = addr;
      host_req.wr_data = wdata;
      do begin
         @(negedge clk);
         waited++;
      end while (!host_rsp.ack && waited < 8);
      if (!host_rsp.ack) begin
         $display("No ack for the access at offset %0d at t=%0t", addr, $time);
         errors++;
      end
      check("ack latency", 32'd1, 32'(waited));
      rdata        = host_rsp.rd_data;
      host_req.req = 1'b0;
      @(negedge clk);
      if (host_rsp.ack) begin
         $display("Second ack for one access at offset %0d at t=%0t", addr, $time);
         errors++;
      end
      idle_gap();
   endtask

   task automatic reg_read(input logic [2:0] addr, input string name, input logic [31:0] exp);
      logic [31:0] rd;
      reg_access(1'b1, addr, '0, rd);
      check(name, exp, rd);
   endtask

   task automatic run_scenario(input int s);
      int          base;
      int          n;
      int          waited;
      int          errs_before;
      logic        lock_exp;
      logic [2:0]  src_exp;
      logic [31:0] clr;
      logic [31:0] rd;
      base        = s * NCOL;
      n           = td[base];
      errs_before = errors;
      clr         = td[base+C_CLR];
      lock_exp    = 1'b1;
      for (int i = 0; i < 4; i++) begin
         flip_pkt[i]  = td[base+1+3*i];
         flip_word[i] = td[base+2+3*i];
         flip_bit[i]  = td[base+3+3*i];
         // Locked ends low when the last packet is corrupted
         if (flip_pkt[i] == n - 1) begin
            lock_exp = 1'b0;
         end
      end
      src_exp = (td[base+C_GOOD] != 0) ? `PHY_TEST_SRC_PORT : 3'd0;
      idle_gap();
      @(negedge clk);
      num_pkts = 16'(n);
      start    = 1'b1;
      @(negedge clk);
      start  = 1'b0;
      waited = 0;
      while (!done && waited < n * 8 + 100) begin
         @(negedge clk);
         waited++;
      end
      if (!done) begin
         $display("Scenario %0d: done did not rise at t=%0t", s, $time);
         errors++;
      end
      check("pass", td[base+C_PASS], 32'(pass));
      check("done", 32'd1, 32'(done));
      reg_read(`PHY_TEST_RX_STATUS, "STATUS", {13'b0, src_exp, 3'b0, 1'b1, 3'b0, lock_exp,
                                               3'b0, td[base+C_PASS][0], 3'b0, 1'b1});
      reg_read(`PHY_TEST_RX_GOOD_PKT_CNT, "GOOD_PKT_CNT", td[base+C_GOOD]);
      reg_read(`PHY_TEST_RX_ERR_PKT_CNT, "ERR_PKT_CNT", td[base+C_ERR]);
      reg_read(`PHY_TEST_RX_SEQ_NO, "SEQ_NO", td[base+C_SEQ]);
      reg_read(`PHY_TEST_RX_CTRL, "CTRL", 32'h0);
      for (int a = 5; a < 8; a++) begin
         reg_read(3'(a), "unmapped", 32'hDEAD_BEEF);
      end
      if (clr != 0) begin
         reg_access(1'b0, `PHY_TEST_RX_CTRL, clr, rd);
         reg_read(`PHY_TEST_RX_GOOD_PKT_CNT, "GOOD_PKT_CNT after clear",
                  clr[`PHY_TEST_RX_CTRL_RESET_GOOD_POS] ? 32'h0 : td[base+C_GOOD]);
         reg_read(`PHY_TEST_RX_ERR_PKT_CNT, "ERR_PKT_CNT after clear",
                  clr[`PHY_TEST_RX_CTRL_RESET_ERR_POS] ? 32'h0 : td[base+C_ERR]);
      end
      if (errors == errs_before) begin
         scen_ok++;
         $display("Scenario %0d: %0d packets, ok", s, n);
      end else begin
         scen_bad++;
         $display("Scenario %0d: %0d packets, %0d mismatches", s, n, errors - errs_before);
      end
   endtask

   // ==========================================================
   // Main sequence

   initial begin
      seed = 32'he1ee0d66;
      void'($urandom(seed));
      reset    = 1'b1;
      start    = 1'b0;
      num_pkts = '0;
      rx       = '0;
      host_req = '0;
      for (int i = 0; i < 4; i++) begin
         flip_pkt[i]  = 32'hFFFF;
         flip_word[i] = 0;
         flip_bit[i]  = 0;
      end
      for (int i = 0; i < MAX_SCEN * NCOL; i++) begin
         td[i] = '0;
      end
      $readmemh("verif/phy_test_testdata.txt", td);
      // A zero packet count ends the list
      while (n_scen < MAX_SCEN && td[n_scen*NCOL] != 0) begin
         limit += td[n_scen*NCOL] * 8 + 200;
         n_scen++;
      end
      if (n_scen == 0) begin
         $display("No scenarios found in the test data file");
         errors++;
      end
      repeat (16) @(negedge clk);
      reset = 1'b0;
      for (int s = 0; s < n_scen; s++) begin
         run_scenario(s);
      end
      $display("Scenarios: %0d ok, %0d failed", scen_ok, scen_bad);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== verif/phy_test_testdata.txt ====
// num | flip0 pkt word bit | flip1 | flip2 | flip3 | clr | good err seq pass
// All values hex, an unused flip has packet FFFF, clr is the CTRL write data
000A  FFFF 0 0   FFFF 0 0   FFFF 0 0   FFFF 0 0   0  A  0  9      1
000C  2 3 4      5 0 1      9 0 1A     FFFF 0 0   1  9  3  B      0
0006  1 2 0      1 7 1F     5 7 A      FFFF 0 0   2  4  2  5      0
0004  3 0 14     FFFF 0 0   FFFF 0 0   FFFF 0 0   3  3  1  100003 0
0010  FFFF 0 0   FFFF 0 0   FFFF 0 0   FFFF 0 0   0  10 0  F      1
0001  FFFF 0 0   FFFF 0 0   FFFF 0 0   FFFF 0 0   0  1  0  0      1
0002  0 4 7      1 1 F      FFFF 0 0   FFFF 0 0   0  0  2  1      0

// ==== src.f ====
+incdir+include
source/phy_test_pkg.sv
source/phy_test_reg_pkg.sv
source/phy_test_ctrl.sv
source/phy_test_pat_gen.sv
source/phy_test_rx_check.sv
source/phy_test_rx_reg.sv
source/phy_test_top.sv
verif/phy_test_tb.sv

// ==== Bender.yml ====
package:
  name: phy_test

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/phy_test_pkg.sv
      - source/phy_test_reg_pkg.sv
      - source/phy_test_ctrl.sv
      - source/phy_test_pat_gen.sv
      - source/phy_test_rx_check.sv
      - source/phy_test_rx_reg.sv
      - source/phy_test_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/phy_test_tb.sv
